// ==== verilog/i2c_target_pkg.sv ====
/*
 * Shared widths, register count, state and direction types and the
 * structs passed between the I2C target blocks.
 * Register count is tied to the pointer width, so the pointer wraps
 * naturally at the end of the register file.
 */
package i2c_target_pkg;

    localparam int DATA_W     = 8;
    localparam int REG_ADDR_W = 4;
    localparam int REG_COUNT  = 1 << REG_ADDR_W;
    localparam int DIVIDER_W  = 8;

    typedef enum logic [2:0] {
        IDLE,
        DEV_ADDR,
        REG_PTR,
        WRITE,
        READ,
        READ_DONE
    } ctrl_state_t;

    // R/W bit of the address byte
    typedef enum logic {
        DIR_WRITE = 1'b0,
        DIR_READ  = 1'b1
    } dir_t;

    // One-clock events produced at each sample tick
    typedef struct packed {
        logic tick;
        logic scl_rise;
        logic scl_fall;
        logic start_cond;
        logic stop_cond;
        logic sda;
    } bus_event_t;

    typedef struct packed {
        logic tx_load;
        logic tx_shift;
        logic drive_ack;
        logic tx_active;
    } shift_cmd_t;

    typedef struct packed {
        logic              ptr_load;
        logic              wr_en;
        logic              rd_req;
        logic [DATA_W-1:0] data;
    } reg_access_t;

endpackage

// ==== verilog/i2c_line_sampler.sv ====
/*
 * Samples SCL and SDA once every divider+1 clocks after two-flop
 * synchronizers and reports edges, START and STOP as one-clock events.
 * No glitch filtering beyond the synchronizers. The bus controller must
 * hold each SCL phase for at least three sample ticks.
 */
module i2c_line_sampler (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                scl,
    input  logic                                sda,
    input  logic [i2c_target_pkg::DIVIDER_W-1:0] divider,
    output i2c_target_pkg::bus_event_t           events
);
    import i2c_target_pkg::*;

    logic [DIVIDER_W-1:0] div_cnt;
    logic                 tick;
    logic                 scl_meta;
    logic                 scl_sync;
    logic                 sda_meta;
    logic                 sda_sync;
    logic                 scl_q;
    logic                 sda_q;

    // ------------------------------------------------------------
    // Sample tick
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else if (div_cnt == divider) begin
            div_cnt <= '0;
            tick    <= 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            tick    <= 1'b0;
        end
    end

    // Two-flop synchronizers, idle bus is high
    always_ff @(posedge clk) begin
        if (reset) begin
            scl_meta <= 1'b1;
            scl_sync <= 1'b1;
            sda_meta <= 1'b1;
            sda_sync <= 1'b1;
        end else begin
            scl_meta <= scl;
            scl_sync <= scl_meta;
            sda_meta <= sda;
            sda_sync <= sda_meta;
        end
    end

    // ------------------------------------------------------------
    // Held samples and bus conditions
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            scl_q  <= 1'b1;
            sda_q  <= 1'b1;
            events <= '0;
            events.sda <= 1'b1;
        end else begin
            events.tick       <= 1'b0;
            events.scl_rise   <= 1'b0;
            events.scl_fall   <= 1'b0;
            events.start_cond <= 1'b0;
            events.stop_cond  <= 1'b0;
            if (tick) begin
                scl_q <= scl_sync;
                sda_q <= sda_sync;
                events.tick     <= 1'b1;
                events.sda      <= sda_sync;
                events.scl_rise <= !scl_q && scl_sync;
                events.scl_fall <= scl_q && !scl_sync;
                // SDA moves while SCL stays high on both samples
                events.start_cond <= scl_q && scl_sync && sda_q && !sda_sync;
                events.stop_cond  <= scl_q && scl_sync && !sda_q && sda_sync;
            end
        end
    end

endmodule

// ==== verilog/i2c_target_ctrl.sv ====
/*
 * Transaction FSM of the I2C target. Matches a 7-bit address only,
 * no general call and no clock stretching. After a write address the
 * first byte loads the register pointer and later bytes write data.
 * A read continues while the controller ACKs and stops on NACK.
 * All outputs toggle one clock after the bus event that causes them.
 */
module i2c_target_ctrl (
    input  logic                              clk,
    input  logic                              reset,
    input  i2c_target_pkg::bus_event_t         events,
    input  logic [6:0]                        dev,
    input  logic [i2c_target_pkg::DATA_W-1:0] rx_byte,
    output i2c_target_pkg::shift_cmd_t         shift,
    output i2c_target_pkg::reg_access_t        access,
    output logic                              start
);
    import i2c_target_pkg::*;

    ctrl_state_t state;
    logic [3:0]  bit_cnt;
    logic        ack_phase;
    logic        tx_shift;
    logic        tx_load;
    logic        addr_match;
    logic        byte_done;
    dir_t        dir;

    assign addr_match = (rx_byte[DATA_W-1:1] == dev);
    assign dir        = dir_t'(rx_byte[0]);

    // SCL fall that closes the 8th bit of a byte
    assign byte_done = events.scl_fall && (bit_cnt == 4'd8);

    // ------------------------------------------------------------
    // Transaction FSM
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state           <= IDLE;
            bit_cnt         <= '0;
            ack_phase       <= 1'b0;
            tx_shift        <= 1'b0;
            tx_load         <= 1'b0;
            start           <= 1'b0;
            access.ptr_load <= 1'b0;
            access.wr_en    <= 1'b0;
            access.rd_req   <= 1'b0;
        end else begin
            start           <= 1'b0;
            access.ptr_load <= 1'b0;
            access.wr_en    <= 1'b0;
            access.rd_req   <= 1'b0;
            tx_shift        <= 1'b0;
            // Read data returns one clock after the request
            tx_load         <= access.rd_req;

            if (events.tick) begin
                if (events.start_cond) begin
                    state     <= DEV_ADDR;
                    bit_cnt   <= '0;
                    ack_phase <= 1'b0;
                end else if (events.stop_cond) begin
                    state     <= IDLE;
                    ack_phase <= 1'b0;
                end else begin
                    if (events.scl_rise) begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end

                    // End of our ACK slot
                    if (events.scl_fall && ack_phase) begin
                        ack_phase <= 1'b0;
                        bit_cnt   <= '0;
                    end

                    case (state)
                        DEV_ADDR: begin
                            if (byte_done) begin
                                if (addr_match) begin
                                    ack_phase <= 1'b1;
                                    start     <= 1'b1;
                                    if (dir == DIR_READ) begin
                                        state         <= READ;
                                        access.rd_req <= 1'b1;
                                    end else begin
                                        state <= REG_PTR;
                                    end
                                end else begin
                                    state <= IDLE;
                                end
                            end
                        end

                        REG_PTR: begin
                            if (byte_done) begin
                                access.ptr_load <= 1'b1;
                                access.data     <= rx_byte;
                                ack_phase       <= 1'b1;
                                state           <= WRITE;
                            end
                        end

                        WRITE: begin
                            if (byte_done) begin
                                access.wr_en <= 1'b1;
                                access.data  <= rx_byte;
                                ack_phase    <= 1'b1;
                            end
                        end

                        READ: begin
                            // Every low phase presents the next transmit bit
                            if (events.scl_fall) begin
                                tx_shift <= 1'b1;
                                if (bit_cnt == 4'd9) begin
                                    bit_cnt <= '0;
                                end
                            end
                            // Controller ACK bit, sampled while SCL is high
                            if (events.scl_rise && bit_cnt == 4'd8 && !ack_phase) begin
                                if (!events.sda) begin
                                    access.rd_req <= 1'b1;
                                end else begin
                                    state <= READ_DONE;
                                end
                            end
                        end

                        default: begin
                        end
                    endcase
                end
            end
        end
    end

    always_comb begin
        shift.tx_load   = tx_load;
        shift.tx_shift  = tx_shift;
        shift.drive_ack = ack_phase;
        shift.tx_active = (state == READ);
    end

endmodule

// ==== verilog/i2c_shift_unit.sv ====
/*
 * Receive and transmit shift registers of the I2C target and the
 * registered open-drain SDA control. sda_t low pulls SDA low, high
 * releases it. The transmit register carries a leading release bit
 * that is shifted out on the first SCL fall after loading.
 */
module i2c_shift_unit (
    input  logic                              clk,
    input  logic                              reset,
    input  i2c_target_pkg::bus_event_t         events,
    input  i2c_target_pkg::shift_cmd_t         shift,
    input  logic [i2c_target_pkg::DATA_W-1:0] rd_data,
    input  logic                              rd_valid,
    output logic [i2c_target_pkg::DATA_W-1:0] rx_byte,
    output logic                              sda_t
);
    import i2c_target_pkg::*;

    logic [DATA_W:0] tx_reg;

    // MSB first, sampled while SCL is high
    always_ff @(posedge clk) begin
        if (events.scl_rise) begin
            rx_byte <= {rx_byte[DATA_W-2:0], events.sda};
        end
    end

    // ------------------------------------------------------------
    // Transmit register
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            tx_reg <= '1;
        end else if (rd_valid && shift.tx_load) begin
            tx_reg <= {1'b1, rd_data};
        end else if (shift.tx_shift) begin
            // Ones fill in behind the data so the ACK slot is released
            tx_reg <= {tx_reg[DATA_W-1:0], 1'b1};
        end
    end

    // ------------------------------------------------------------
    // SDA drive
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            sda_t <= 1'b1;
        end else if (shift.drive_ack) begin
            sda_t <= 1'b0;
        end else if (shift.tx_active) begin
            sda_t <= tx_reg[DATA_W];
        end else begin
            sda_t <= 1'b1;
        end
    end

endmodule

// ==== verilog/i2c_reg_bank.sv ====
/*
 * 16 x 8 register file behind the I2C target with one shared
 * auto-incrementing pointer. Writes and reads both advance the pointer,
 * which wraps past the last register. Read data is registered and
 * flagged by rd_valid one clock after rd_req.
 */
module i2c_reg_bank (
    input  logic                              clk,
    input  logic                              reset,
    input  i2c_target_pkg::reg_access_t        access,
    output logic [i2c_target_pkg::DATA_W-1:0] rd_data,
    output logic                              rd_valid
);
    import i2c_target_pkg::*;

    logic [DATA_W-1:0]     regs [REG_COUNT];
    logic [REG_ADDR_W-1:0] ptr;

    // ------------------------------------------------------------
    // Pointer and register writes
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= '0;
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (access.ptr_load) begin
                ptr <= access.data[REG_ADDR_W-1:0];
            end else if (access.wr_en) begin
                regs[ptr] <= access.data;
                ptr       <= ptr + 1'b1;
            end else if (access.rd_req) begin
                ptr <= ptr + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= access.rd_req;
        end
    end

    // Byte at the pointer before it advances
    always_ff @(posedge clk) begin
        if (access.rd_req) begin
            rd_data <= regs[ptr];
        end
    end

endmodule

// ==== verilog/i2c_target_top.sv ====
/*
 * I2C target with a 16-register bank. scl and sda are the bus levels,
 * sda_t low pulls SDA low. divider sets the sample rate to one tick
 * every divider+1 clocks. start and access are observation outputs.
 */
module i2c_target_top (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                scl,
    input  logic                                sda,
    output logic                                sda_t,
    input  logic [i2c_target_pkg::DIVIDER_W-1:0] divider,
    input  logic [6:0]                          dev,
    output logic                                start,
    output i2c_target_pkg::reg_access_t          access
);
    import i2c_target_pkg::*;

    bus_event_t        events;
    shift_cmd_t        shift;
    logic [DATA_W-1:0] rx_byte;
    logic [DATA_W-1:0] rd_data;
    logic              rd_valid;

    i2c_line_sampler u_sampler (
        .clk     (clk),
        .reset   (reset),
        .scl     (scl),
        .sda     (sda),
        .divider (divider),
        .events  (events)
    );

    i2c_target_ctrl u_ctrl (
        .clk     (clk),
        .reset   (reset),
        .events  (events),
        .dev     (dev),
        .rx_byte (rx_byte),
        .shift   (shift),
        .access  (access),
        .start   (start)
    );

    i2c_shift_unit u_shift (
        .clk      (clk),
        .reset    (reset),
        .events   (events),
        .shift    (shift),
        .rd_data  (rd_data),
        .rd_valid (rd_valid),
        .rx_byte  (rx_byte),
        .sda_t    (sda_t)
    );

    i2c_reg_bank u_regs (
        .clk      (clk),
        .reset    (reset),
        .access   (access),
        .rd_data  (rd_data),
        .rd_valid (rd_valid)
    );

endmodule

// ==== dv/i2c_clock_gen.sv ====
/*
 * Clock and reset source for the I2C target testbench.
 * 20 ns clock period. Reset is high for the first 10 clocks and is
 * released on a falling edge.
 */
module i2c_clock_gen (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// ==== dv/i2c_target_tb.sv ====
/*
 * Testbench for the I2C target. Acts as the bus controller with
 * 40-clock SCL phases and a sample divider of 3, so each phase spans
 * ten sample ticks. Data bits change SDA only in the middle of SCL low.
 * A reference register model predicts read data and access strobes.
 */
module i2c_target_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import i2c_target_pkg::*;

    localparam int         HALF_CLKS      = 40;
    localparam int         TIMEOUT_CYCLES = 60 * 30 * 9 * 80 + 100000;
    localparam logic [6:0] TARGET_DEV     = 7'h52;

    logic                  clk;
    logic                  reset;
    logic                  scl;
    logic                  sda_in;
    logic                  sda_bus;
    logic                  sda_t;
    logic [DIVIDER_W-1:0]  divider;
    logic [6:0]            dev;
    logic                  start;
    reg_access_t           access;

    logic [DATA_W-1:0]     ref_regs [REG_COUNT];
    logic [REG_ADDR_W-1:0] ref_ptr;
    reg_access_t           exp_q [$];
    reg_access_t           got_q [$];
    logic                  start_seen;
    int                    error_count;
    int                    check_count;
    int                    cycles;

    // Open-drain bus where either side can pull SDA low
    assign sda_bus = sda_in & sda_t;

    i2c_clock_gen clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    i2c_target_top DUT (
        .clk     (clk),
        .reset   (reset),
        .scl     (scl),
        .sda     (sda_bus),
        .sda_t   (sda_t),
        .divider (divider),
        .dev     (dev),
        .start   (start),
        .access  (access)
    );

    // ------------------------------------------------------------
    // Reference register model
    // ------------------------------------------------------------
    function automatic logic [DATA_W-1:0] ref_read();
        logic [DATA_W-1:0] value;
        value   = ref_regs[ref_ptr];
        ref_ptr = ref_ptr + 1'b1;
        return value;
    endfunction

    function automatic void ref_write(input logic [DATA_W-1:0] value);
        ref_regs[ref_ptr] = value;
        ref_ptr           = ref_ptr + 1'b1;
    endfunction

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    function automatic string access_text(input reg_access_t acc);
        return $sformatf("ptr_load=%b wr_en=%b rd_req=%b data=0x%02h",
                         acc.ptr_load, acc.wr_en, acc.rd_req, acc.data);
    endfunction

    task automatic check_byte(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                              input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error @ %0t: %s got 0x%02h, expected 0x%02h", $time, what, got, exp);
        end
    endtask

    task automatic check_ack(input logic got, input logic exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error @ %0t: %s got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_access(input reg_access_t got, input reg_access_t exp);
        logic data_bad;
        check_count++;
        // A read request carries no data
        data_bad = !exp.rd_req && (got.data !== exp.data);
        if (got.ptr_load !== exp.ptr_load || got.wr_en !== exp.wr_en ||
            got.rd_req !== exp.rd_req || data_bad) begin
            error_count++;
            $display("** Error @ %0t: access got %s, expected %s", $time,
                     access_text(got), access_text(exp));
        end
    endtask

    // ------------------------------------------------------------
    // Bus controller
    // ------------------------------------------------------------
    task automatic wait_clocks(input int n);
        repeat (n) @(negedge clk);
    endtask

    // One bit period with SDA set mid-low and sampled mid-high
    task automatic clock_bit(input logic drive, output logic level);
        scl = 1'b0;
        wait_clocks(HALF_CLKS / 2);
        sda_in = drive;
        wait_clocks(HALF_CLKS / 2);
        scl = 1'b1;
        wait_clocks(HALF_CLKS / 2);
        level = sda_bus;
        wait_clocks(HALF_CLKS / 2);
    endtask

    // Also serves as repeated START
    task automatic bus_start();
        scl = 1'b0;
        wait_clocks(HALF_CLKS / 2);
        sda_in = 1'b1;
        wait_clocks(HALF_CLKS / 2);
        scl = 1'b1;
        wait_clocks(HALF_CLKS);
        sda_in = 1'b0;
        wait_clocks(HALF_CLKS);
    endtask

    task automatic bus_stop(input logic check_release);
        scl = 1'b0;
        wait_clocks(HALF_CLKS / 2);
        if (check_release) begin
            check_ack(sda_t, 1'b1, "SDA release after NACK");
        end
        sda_in = 1'b0;
        wait_clocks(HALF_CLKS / 2);
        scl = 1'b1;
        wait_clocks(HALF_CLKS);
        sda_in = 1'b1;
        wait_clocks(HALF_CLKS);
    endtask

    task automatic bus_write_byte(input logic [DATA_W-1:0] value, output logic ack);
        logic level;
        for (int i = DATA_W - 1; i >= 0; i--) begin
            clock_bit(value[i], level);
        end
        clock_bit(1'b1, ack);
    endtask

    task automatic bus_read_byte(input logic ack_bit, output logic [DATA_W-1:0] value);
        logic level;
        for (int i = DATA_W - 1; i >= 0; i--) begin
            clock_bit(1'b1, value[i]);
        end
        clock_bit(ack_bit, level);
    endtask

    // ------------------------------------------------------------
    // Transactions
    // ------------------------------------------------------------
    task automatic send_address(input logic [6:0] addr, input dir_t dir, input logic exp_ack);
        logic ack;
        start_seen = 1'b0;
        bus_write_byte({addr, dir}, ack);
        check_ack(ack, exp_ack, "address ACK");
        check_ack(start_seen, !exp_ack, "start pulse");
    endtask

    task automatic load_pointer(input logic [REG_ADDR_W-1:0] ptr);
        reg_access_t exp;
        logic        ack;
        send_address(TARGET_DEV, DIR_WRITE, 1'b0);
        exp          = '0;
        exp.ptr_load = 1'b1;
        exp.data     = DATA_W'(ptr);
        exp_q.push_back(exp);
        bus_write_byte(DATA_W'(ptr), ack);
        check_ack(ack, 1'b0, "pointer byte ACK");
        ref_ptr = ptr;
    endtask

    task automatic write_regs(input logic [REG_ADDR_W-1:0] ptr, input int count);
        reg_access_t       exp;
        logic [DATA_W-1:0] value;
        logic              ack;
        bus_start();
        load_pointer(ptr);
        for (int i = 0; i < count; i++) begin
            value     = DATA_W'($urandom);
            exp       = '0;
            exp.wr_en = 1'b1;
            exp.data  = value;
            exp_q.push_back(exp);
            bus_write_byte(value, ack);
            check_ack(ack, 1'b0, "data byte ACK");
            ref_write(value);
        end
        bus_stop(1'b0);
    endtask

    task automatic read_regs(input logic [REG_ADDR_W-1:0] ptr, input int count);
        reg_access_t       exp;
        logic [DATA_W-1:0] value;
        bus_start();
        load_pointer(ptr);
        // One read request per byte, the last one NACKed
        exp        = '0;
        exp.rd_req = 1'b1;
        for (int i = 0; i < count; i++) begin
            exp_q.push_back(exp);
        end
        bus_start();
        send_address(TARGET_DEV, DIR_READ, 1'b0);
        for (int i = 0; i < count; i++) begin
            // NACK on the last byte ends the read
            bus_read_byte(i == count - 1, value);
            check_byte(value, ref_read(), "read data");
        end
        bus_stop(1'b1);
    endtask

    // Access monitor and compare process
    always @(negedge clk) begin
        if (!reset) begin
            if (access.wr_en || access.ptr_load || access.rd_req) begin
                got_q.push_back(access);
            end
            if (start) begin
                start_seen = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        reg_access_t got;
        while (got_q.size() > 0) begin
            got = got_q.pop_front();
            if (exp_q.size() == 0) begin
                error_count++;
                $display("** Error @ %0t: unexpected access strobe %s",
                         $time, access_text(got));
            end else begin
                check_access(got, exp_q.pop_front());
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d clock cycles, the test sequence did not finish", cycles);
        $display("Simulation failed");
        $finish;
    end

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        logic                  ack;
        logic                  level;
        logic [REG_ADDR_W-1:0] ptr;
        int                    count;
        scl         = 1'b1;
        sda_in      = 1'b1;
        divider     = DIVIDER_W'(3);
        dev         = TARGET_DEV;
        start_seen  = 1'b0;
        error_count = 0;
        check_count = 0;
        ref_ptr     = '0;
        for (int i = 0; i < REG_COUNT; i++) begin
            ref_regs[i] = '0;
        end
        void'($urandom(87));
        wait (reset === 1'b0);

        // Quiet outputs before the first START
        repeat (20) begin
            @(negedge clk);
            check_ack(start, 1'b0, "start before first START");
            check_ack(access.wr_en, 1'b0, "wr_en before first START");
            check_ack(access.ptr_load, 1'b0, "ptr_load before first START");
            check_ack(sda_t, 1'b1, "sda_t before first START");
        end
        read_regs('0, REG_COUNT);

        // Foreign address and then our own after a repeated START
        bus_start();
        send_address(TARGET_DEV ^ 7'h01, DIR_WRITE, 1'b1);
        bus_write_byte(8'hA5, ack);
        check_ack(ack, 1'b1, "byte after NACKed address");
        bus_start();
        load_pointer(4'd3);
        bus_stop(1'b0);

        // Pointer wraps past register 15
        write_regs(4'd13, 6);
        read_regs(4'd12, 8);

        repeat (40) begin
            ptr   = REG_ADDR_W'($urandom % REG_COUNT);
            count = 1 + int'($urandom % 20);
            if ($urandom % 2) begin
                read_regs(ptr, count);
            end else begin
                write_regs(ptr, count);
            end
        end

        // STOP after half a data byte
        bus_start();
        load_pointer(4'd7);
        for (int i = 0; i < 4; i++) begin
            clock_bit(i[0], level);
        end
        bus_stop(1'b0);
        write_regs(4'd7, 3);
        read_regs('0, REG_COUNT);

        wait_clocks(100);
        if (exp_q.size() != 0) begin
            error_count++;
            $display("%0d expected access strobes never appeared", exp_q.size());
        end
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
verilog/i2c_target_pkg.sv
verilog/i2c_line_sampler.sv
verilog/i2c_target_ctrl.sv
verilog/i2c_shift_unit.sv
verilog/i2c_reg_bank.sv
verilog/i2c_target_top.sv
dv/i2c_clock_gen.sv
dv/i2c_target_tb.sv
